// ==== compile.f ====
+incdir+verilog
verilog/msr_pkg.sv
verilog/msr_if.sv
verilog/msr_psr.sv
verilog/msr_access.sv
verilog/exc_entry.sv
verilog/msr_top.sv
bench/msr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= msr_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

PASS_MSG  := Simulation completed successfully
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/msr_tb.sv ====
// MSR subsystem testbench
// Directed tests against a small register model, LCG data and a cycle timeout
`timescale 1ns/1ps

`include "msr_settings.svh"

module msr_tb import msr_pkg::*; ();

   localparam int    MAX_CYCLES = 400;
   localparam data_t CC_M   = data_t'(1) << `MSR_PSR_CC_BIT;
   localparam data_t RM_M   = data_t'(1) << `MSR_PSR_RM_BIT;
   localparam data_t PSR_M  = CC_M | RM_M | (data_t'(1) << `MSR_PSR_IRE_BIT) |
                              (data_t'(1) << `MSR_PSR_IMME_BIT) |
                              (data_t'(1) << `MSR_PSR_DMME_BIT);
   localparam data_t EPSR_M = (data_t'(1) << `MSR_PSR_DW) - 1;

   logic clk, rst_n, msr_we, alu_cc_we, alu_cc, syscall, eret, handler_mode;
   msr_addr_t msr_addr;
   data_t msr_wdat, msr_rdat, epc_in, lsa_in, epc;
   psr_t psr;

   data_t m_reg [4];          // Expected PSR, EPSR, EPC, ELSA by address
   logic  m_hm;               // Expected handler mode
   data_t lcg_state = 32'hdc175d00;
   int    errors = 0, checks = 0, cycle_cnt = 0;

   msr_top UUT (.*);

   always #10 clk = ~clk;   // 20 ns period

   // Timeout guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout, run exceeded %0d cycles", MAX_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   function automatic data_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Register view of a software write, by address
   function automatic data_t sw_view(input int a, input data_t v);
      if (a == `MSR_ADDR_PSR) return v & PSR_M;
      if (a == `MSR_ADDR_EPSR) return v & EPSR_M;
      return v;
   endfunction

   task automatic check_eq(input string name, input data_t exp, input data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic set_idle();
      msr_we    = 0;
      alu_cc_we = 0;
      alu_cc    = 0;
      syscall   = 0;
      eret      = 0;
   endtask

   // Quiet cycle that checks all readback paths against the model
   task automatic idle_cycle();
      @(negedge clk);
      set_idle();
      for (int a = 0; a < 4; a++) begin
         msr_addr = msr_addr_t'(a);
         #1 check_eq($sformatf("msr_rdat[%0d]", a), m_reg[a], msr_rdat);
      end
      check_eq("psr", m_reg[`MSR_ADDR_PSR], data_t'(psr));
      check_eq("epc", m_reg[`MSR_ADDR_EPC], epc);
      check_eq("handler_mode", data_t'(m_hm), data_t'(handler_mode));
   endtask

   task automatic sw_write(input int a, input data_t v);
      @(negedge clk);
      set_idle();
      msr_we   = 1;
      msr_addr = msr_addr_t'(a);
      msr_wdat = v;
      #1 check_eq("msr_rdat bypass", sw_view(a, v), msr_rdat);
      m_reg[a] = sw_view(a, v);
   endtask

   // Syscall with a clashing EPC write, optionally with eret in the same cycle
   task automatic syscall_cycle(input logic with_eret);
      @(negedge clk);
      set_idle();
      syscall  = 1;
      eret     = with_eret;
      epc_in   = lcg_next();
      lsa_in   = lcg_next();
      msr_we   = 1;
      msr_addr = msr_addr_t'(`MSR_ADDR_EPC);
      msr_wdat = lcg_next();
      m_reg[`MSR_ADDR_EPSR] = m_reg[`MSR_ADDR_PSR];
      m_reg[`MSR_ADDR_PSR]  = (m_reg[`MSR_ADDR_PSR] & CC_M) | RM_M;   // cc kept
      m_reg[`MSR_ADDR_EPC]  = epc_in;
      m_reg[`MSR_ADDR_ELSA] = lsa_in;
      m_hm = 1;
      #1 check_eq("psr on syscall", m_reg[`MSR_ADDR_PSR], data_t'(psr));
   endtask

   task automatic test_done(input string name, input int err0);
      $display("Test %s finished, %0d errors", name, errors - err0);
   endtask

   // ============================================================
   // Tests
   // ============================================================
   task automatic test_reset();
      int e0 = errors;
      idle_cycle();
      test_done("reset_values", e0);
   endtask

   task automatic test_sw_write();
      int e0 = errors;
      int order [4] = '{`MSR_ADDR_EPSR, `MSR_ADDR_EPC, `MSR_ADDR_ELSA, `MSR_ADDR_PSR};
      foreach (order[i]) begin
         sw_write(order[i], lcg_next());
         idle_cycle();   // Value held after the edge
      end
      test_done("sw_write", e0);
   endtask

   task automatic test_cc();
      int e0 = errors;
      @(negedge clk);
      alu_cc_we = 1;
      alu_cc    = ~m_reg[`MSR_ADDR_PSR][`MSR_PSR_CC_BIT];
      m_reg[`MSR_ADDR_PSR][`MSR_PSR_CC_BIT] = alu_cc;
      #1 check_eq("psr alu cc", m_reg[`MSR_ADDR_PSR], data_t'(psr));
      idle_cycle();
      // Software value wins over the ALU in the same cycle
      @(negedge clk);
      alu_cc_we = 1;
      alu_cc    = 1;
      msr_we    = 1;
      msr_addr  = msr_addr_t'(`MSR_ADDR_PSR);
      msr_wdat  = lcg_next() & ~CC_M;
      m_reg[`MSR_ADDR_PSR] = msr_wdat & PSR_M;
      #1 check_eq("psr sw over alu", m_reg[`MSR_ADDR_PSR], data_t'(psr));
      idle_cycle();
      test_done("cond_flag", e0);
   endtask

   task automatic test_syscall();
      int e0 = errors;
      sw_write(`MSR_ADDR_PSR, lcg_next() | PSR_M);   // All flags set so entry clears each
      idle_cycle();
      syscall_cycle(0);
      idle_cycle();
      test_done("syscall", e0);
   endtask

   task automatic test_eret();
      int e0 = errors;
      @(negedge clk);
      eret = 1;
      m_reg[`MSR_ADDR_PSR] = m_reg[`MSR_ADDR_EPSR] & PSR_M;
      m_hm = 0;
      #1 check_eq("psr on eret", m_reg[`MSR_ADDR_PSR], data_t'(psr));
      idle_cycle();
      sw_write(`MSR_ADDR_PSR, ~m_reg[`MSR_ADDR_EPSR]);   // PSR now differs from EPSR
      idle_cycle();
      @(negedge clk);
      eret = 1;        // Ignored in user mode
      #1 check_eq("psr user eret", m_reg[`MSR_ADDR_PSR], data_t'(psr));
      idle_cycle();
      test_done("eret", e0);
   endtask

   task automatic test_syscall_eret();
      int e0 = errors;
      sw_write(`MSR_ADDR_PSR, lcg_next());
      idle_cycle();
      syscall_cycle(0);
      idle_cycle();
      syscall_cycle(1);   // Eret in handler mode loses to syscall
      idle_cycle();
      test_done("syscall_eret", e0);
   endtask

   initial begin
      clk      = 0;
      rst_n    = 0;
      msr_addr = '0;
      msr_wdat = '0;
      epc_in   = '0;
      lsa_in   = '0;
      set_idle();
      m_reg = '{PSR_M & ~CC_M, '0, '0, '0};   // Reset model
      m_hm = 0;
      repeat (3) @(posedge clk);
      @(negedge clk) rst_n = 1;
      test_reset();
      test_sw_write();
      test_cc();
      test_syscall();
      test_eret();
      test_syscall_eret();
      $display("Tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) $display("Simulation completed successfully");
      else $display("Simulation failed");
      $finish;
   end

endmodule

// ==== verilog/msr_top.sv ====
// MSR subsystem top
// Connects access port, exception logic and register file behind plain ports
`timescale 1ns/1ps

`include "msr_settings.svh"

module msr_top import msr_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   // Core access port
   input  logic      msr_we,
   input  msr_addr_t msr_addr,
   input  data_t     msr_wdat,
   output data_t     msr_rdat,
   // ALU flag
   input  logic      alu_cc_we,
   input  logic      alu_cc,
   // Exceptions
   input  logic      syscall,
   input  logic      eret,
   input  data_t     epc_in,
   input  data_t     lsa_in,
   // Status to the core
   output psr_t      psr,
   output data_t     epc,
   output logic      handler_mode
);

   // ============================================================
   // Bundles
   // ============================================================
   msr_wr_if sw_wr ();    // Decoded software writes
   msr_wr_if psr_wr ();   // After exception overrides
   msr_rd_if rd ();       // Bypassed register values

   msr_access u_access (
      .msr_we, .msr_addr, .msr_wdat, .msr_rdat,
      .alu_cc_we, .alu_cc,
      .sw_wr (sw_wr.src),
      .rd    (rd.dst)
   );

   exc_entry u_exc (
      .clk, .rst_n, .syscall, .eret, .epc_in, .lsa_in, .handler_mode,
      .sw_wr  (sw_wr.dst),
      .rd     (rd.dst),
      .psr_wr (psr_wr.src)
   );

   msr_psr u_psr (
      .clk, .rst_n,
      .wr (psr_wr.dst),
      .rd (rd.src)
   );

   assign psr = rd.psr;   // Same cycle view
   assign epc = rd.epc;

endmodule

// ==== verilog/exc_entry.sv ====
// Exception entry and return
// Handler mode FSM, overrides software writes with the syscall save and eret restore
`timescale 1ns/1ps

`include "msr_settings.svh"

module exc_entry import msr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  syscall,        // Entry pulse
   input  logic  eret,           // Return pulse
   input  data_t epc_in,         // Return PC to save
   input  data_t lsa_in,         // Load/store address to save
   output logic  handler_mode,
   msr_wr_if.dst sw_wr,          // Software writes
   msr_rd_if.dst rd,             // Bypassed register values
   msr_wr_if.src psr_wr          // Merged writes to register file
);

   // PSR after reset, matches register file reset values
   localparam psr_t PSR_RST = psr_t'((1 << `MSR_PSR_RM_BIT) | (1 << `MSR_PSR_IRE_BIT) |
                                     (1 << `MSR_PSR_IMME_BIT) | (1 << `MSR_PSR_DMME_BIT));

   exc_state_t state;
   logic       eret_ok;    // Eret accepted this cycle
   psr_t       psr_prev;   // PSR as stored before this cycle

   // Syscall wins over eret, eret ignored in user mode
   assign eret_ok      = eret & ~syscall & (state == EXC_HANDLER);
   assign handler_mode = (state == EXC_HANDLER);

   // ============================================================
   // Handler FSM and PSR snapshot
   // ============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= EXC_USER;
         psr_prev <= PSR_RST;
      end else begin
         psr_prev <= rd.psr;                             // Equals stored PSR next cycle
         if (syscall)      state <= EXC_HANDLER;
         else if (eret_ok) state <= EXC_USER;
      end
   end

   // ============================================================
   // Write merge
   // ============================================================
   // Eret restores all five fields from EPSR
   assign psr_wr.cc_we    = sw_wr.cc_we | eret_ok;
   assign psr_wr.cc_nxt   = eret_ok ? rd.epsr[`MSR_PSR_CC_BIT] : sw_wr.cc_nxt;
   assign psr_wr.rm_we    = sw_wr.rm_we | eret_ok;
   assign psr_wr.rm_nxt   = eret_ok ? rd.epsr[`MSR_PSR_RM_BIT] : sw_wr.rm_nxt;
   assign psr_wr.ire_we   = sw_wr.ire_we | eret_ok;
   assign psr_wr.ire_nxt  = eret_ok ? rd.epsr[`MSR_PSR_IRE_BIT] : sw_wr.ire_nxt;
   assign psr_wr.imme_we  = sw_wr.imme_we | eret_ok;
   assign psr_wr.imme_nxt = eret_ok ? rd.epsr[`MSR_PSR_IMME_BIT] : sw_wr.imme_nxt;
   assign psr_wr.dmme_we  = sw_wr.dmme_we | eret_ok;
   assign psr_wr.dmme_nxt = eret_ok ? rd.epsr[`MSR_PSR_DMME_BIT] : sw_wr.dmme_nxt;

   // Syscall saves context, software writes to these are lost
   assign psr_wr.epsr_we  = sw_wr.epsr_we | syscall;
   assign psr_wr.epsr_nxt = syscall ? psr_prev : sw_wr.epsr_nxt;
   assign psr_wr.epc_we   = sw_wr.epc_we | syscall;
   assign psr_wr.epc_nxt  = syscall ? epc_in : sw_wr.epc_nxt;
   assign psr_wr.elsa_we  = sw_wr.elsa_we | syscall;
   assign psr_wr.elsa_nxt = syscall ? lsa_in : sw_wr.elsa_nxt;

   assign psr_wr.syscall_ent = syscall | sw_wr.syscall_ent;   // Flag forcing in reg file

endmodule

// ==== verilog/msr_access.sv ====
// MSR access port
// Decodes core writes by address, merges the ALU flag write and muxes reads
`timescale 1ns/1ps

`include "msr_settings.svh"

module msr_access import msr_pkg::*; (
   input  logic      msr_we,      // Software write strobe
   input  msr_addr_t msr_addr,    // Register select, read and write
   input  data_t     msr_wdat,
   output data_t     msr_rdat,
   input  logic      alu_cc_we,   // Flag update from ALU
   input  logic      alu_cc,
   msr_wr_if.src     sw_wr,       // Decoded software writes
   msr_rd_if.dst     rd           // Bypassed values for readback
);

   logic wr_psr;
   logic wr_epsr;
   logic wr_epc;
   logic wr_elsa;

   // ============================================================
   // Address decode
   // ============================================================
   assign wr_psr  = msr_we & (msr_addr == msr_addr_t'(`MSR_ADDR_PSR));
   assign wr_epsr = msr_we & (msr_addr == msr_addr_t'(`MSR_ADDR_EPSR));
   assign wr_epc  = msr_we & (msr_addr == msr_addr_t'(`MSR_ADDR_EPC));
   assign wr_elsa = msr_we & (msr_addr == msr_addr_t'(`MSR_ADDR_ELSA));

   // Condition flag, software write beats ALU
   assign sw_wr.cc_we  = wr_psr | alu_cc_we;
   assign sw_wr.cc_nxt = wr_psr ? msr_wdat[`MSR_PSR_CC_BIT] : alu_cc;

   // Remaining PSR fields only from software
   assign sw_wr.rm_we    = wr_psr;
   assign sw_wr.rm_nxt   = msr_wdat[`MSR_PSR_RM_BIT];
   assign sw_wr.ire_we   = wr_psr;
   assign sw_wr.ire_nxt  = msr_wdat[`MSR_PSR_IRE_BIT];
   assign sw_wr.imme_we  = wr_psr;
   assign sw_wr.imme_nxt = msr_wdat[`MSR_PSR_IMME_BIT];
   assign sw_wr.dmme_we  = wr_psr;
   assign sw_wr.dmme_nxt = msr_wdat[`MSR_PSR_DMME_BIT];

   // Whole register writes
   assign sw_wr.epsr_we  = wr_epsr;
   assign sw_wr.epsr_nxt = msr_wdat[`MSR_PSR_DW-1:0];   // Upper bits dropped
   assign sw_wr.epc_we   = wr_epc;
   assign sw_wr.epc_nxt  = msr_wdat;
   assign sw_wr.elsa_we  = wr_elsa;
   assign sw_wr.elsa_nxt = msr_wdat;

   assign sw_wr.syscall_ent = 1'b0;   // Entry only from exception logic

   // ============================================================
   // Read mux
   // ============================================================
   always_comb begin
      case (msr_addr)
         msr_addr_t'(`MSR_ADDR_PSR):  msr_rdat = data_t'(rd.psr);    // Zero extend
         msr_addr_t'(`MSR_ADDR_EPSR): msr_rdat = data_t'(rd.epsr);
         msr_addr_t'(`MSR_ADDR_EPC):  msr_rdat = rd.epc;
         msr_addr_t'(`MSR_ADDR_ELSA): msr_rdat = rd.elsa;
         default:                     msr_rdat = '0;
      endcase
   end

endmodule

// ==== verilog/msr_psr.sv ====
// Status register file
// PSR flags, EPSR, EPC and ELSA as load-enable flops with same-cycle write bypass
`timescale 1ns/1ps

`include "msr_settings.svh"

module msr_psr import msr_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   msr_wr_if.dst wr,    // Merged writes from exception logic
   msr_rd_if.src rd     // Bypassed register values
);

   // Flag vector order is {dmme, imme, ire, rm, cc}
   localparam int             FLAG_N   = 5;
   localparam logic [FLAG_N-1:0] FLAG_RST = 5'b11110;   // cc clear, rest set

   logic [FLAG_N-1:0] flag_we;    // Effective load enables
   logic [FLAG_N-1:0] flag_nxt;   // Effective next values
   logic [FLAG_N-1:0] flag_q;     // Stored flags
   logic [FLAG_N-1:0] flag_d;     // Bypassed flags
   psr_t              epsr_q;
   psr_t              epsr_d;
   data_t             epc_q;
   data_t             epc_d;
   data_t             elsa_q;
   data_t             elsa_d;
   psr_t              psr_pk;

   // ============================================================
   // Syscall forcing
   // ============================================================
   // Entry loads rm/ire/imme/dmme regardless of their own enables
   assign flag_we = {wr.dmme_we | wr.syscall_ent,
                     wr.imme_we | wr.syscall_ent,
                     wr.ire_we  | wr.syscall_ent,
                     wr.rm_we   | wr.syscall_ent,
                     wr.cc_we};                     // cc untouched by entry

   // Root mode set, interrupts and both MMUs off
   assign flag_nxt = {wr.dmme_nxt & ~wr.syscall_ent,
                      wr.imme_nxt & ~wr.syscall_ent,
                      wr.ire_nxt  & ~wr.syscall_ent,
                      wr.rm_nxt   |  wr.syscall_ent,
                      wr.cc_nxt};

   // ============================================================
   // Bypass, the value shown is also the value stored
   // ============================================================
   assign flag_d = (flag_we & flag_nxt) | (~flag_we & flag_q);   // Per bit select
   assign epsr_d = wr.epsr_we ? wr.epsr_nxt : epsr_q;
   assign epc_d  = wr.epc_we  ? wr.epc_nxt  : epc_q;
   assign elsa_d = wr.elsa_we ? wr.elsa_nxt : elsa_q;

   // Registers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         flag_q <= FLAG_RST;
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end else begin
         flag_q <= flag_d;    // Holds when no enable
         epsr_q <= epsr_d;
         epc_q  <= epc_d;
         elsa_q <= elsa_d;
      end
   end

   // ============================================================
   // PSR packing
   // ============================================================
   always_comb begin
      psr_pk                      = '0;          // Reserved bits read 0
      psr_pk[`MSR_PSR_CC_BIT]     = flag_d[0];
      psr_pk[`MSR_PSR_RM_BIT]     = flag_d[1];
      psr_pk[`MSR_PSR_IRE_BIT]    = flag_d[2];
      psr_pk[`MSR_PSR_IMME_BIT]   = flag_d[3];
      psr_pk[`MSR_PSR_DMME_BIT]   = flag_d[4];
   end

   assign rd.psr  = psr_pk;
   assign rd.epsr = epsr_d;
   assign rd.epc  = epc_d;
   assign rd.elsa = elsa_d;

endmodule

// ==== verilog/msr_if.sv ====
// MSR write and read bundles
// Write side carries next value and enable per register, read side the bypassed values
`timescale 1ns/1ps

`include "msr_settings.svh"

// ============================================================
// Write bundle
// ============================================================
interface msr_wr_if import msr_pkg::*; ();
   logic  cc_nxt,   cc_we;     // PSR condition flag
   logic  rm_nxt,   rm_we;     // PSR root mode
   logic  ire_nxt,  ire_we;    // PSR interrupt enable
   logic  imme_nxt, imme_we;   // PSR IMMU enable
   logic  dmme_nxt, dmme_we;   // PSR DMMU enable
   psr_t  epsr_nxt;            // Whole register writes
   logic  epsr_we;
   data_t epc_nxt;
   logic  epc_we;
   data_t elsa_nxt;
   logic  elsa_we;
   logic  syscall_ent;         // Force handler entry flags

   modport src (output cc_nxt, cc_we, rm_nxt, rm_we, ire_nxt, ire_we,
                       imme_nxt, imme_we, dmme_nxt, dmme_we,
                       epsr_nxt, epsr_we, epc_nxt, epc_we, elsa_nxt, elsa_we,
                       syscall_ent);
   modport dst (input  cc_nxt, cc_we, rm_nxt, rm_we, ire_nxt, ire_we,
                       imme_nxt, imme_we, dmme_nxt, dmme_we,
                       epsr_nxt, epsr_we, epc_nxt, epc_we, elsa_nxt, elsa_we,
                       syscall_ent);
endinterface

// ============================================================
// Read bundle
// ============================================================
interface msr_rd_if import msr_pkg::*; ();
   psr_t  psr;    // Packed, includes same cycle writes
   psr_t  epsr;
   data_t epc;
   data_t elsa;

   modport src (output psr, epsr, epc, elsa);
   modport dst (input  psr, epsr, epc, elsa);
endinterface

// ==== verilog/msr_pkg.sv ====
// MSR package
// Shared vector types and the handler mode FSM encoding

`include "msr_settings.svh"

package msr_pkg;

   // ============================================================
   // Vector types
   // ============================================================

   // Data word, also used for PCs and load/store addresses
   typedef logic [`MSR_DW-1:0]     data_t;

   // Packed PSR as seen by software
   typedef logic [`MSR_PSR_DW-1:0] psr_t;

   // Special register select
   typedef logic [`MSR_ADDR_W-1:0] msr_addr_t;

   // Handler mode FSM
   typedef enum logic {
      EXC_USER    = 1'b0,   // Normal execution
      EXC_HANDLER = 1'b1    // Inside syscall handler
   } exc_state_t;

endpackage

// ==== verilog/msr_settings.svh ====
// Machine status register settings
// Architectural widths, PSR bit map and special register addresses
`ifndef MSR_SETTINGS_SVH
`define MSR_SETTINGS_SVH

// ============================================================
// Widths
// ============================================================
`define MSR_DW            32   // Data and address word
`define MSR_PSR_DW        10   // Packed PSR, unused bits read 0

// PSR bit positions
`define MSR_PSR_CC_BIT    0    // Condition flag
`define MSR_PSR_RM_BIT    3    // Root (privileged) mode
`define MSR_PSR_IRE_BIT   4    // Interrupt enable
`define MSR_PSR_IMME_BIT  5    // Instruction MMU enable
`define MSR_PSR_DMME_BIT  6    // Data MMU enable

// Special register addresses
`define MSR_ADDR_W        2
`define MSR_ADDR_PSR      0
`define MSR_ADDR_EPSR     1
`define MSR_ADDR_EPC      2
`define MSR_ADDR_ELSA     3

`endif
